/* rtl/vsaPkg.sv */
// shared types for the vsa16 core
// state, opcode and ALU function encodings
// instruction field and decode structs, field and immediate extraction
`default_nettype none

package vsaPkg;

    typedef logic [15:0] wordT;     // data or instruction word
    typedef logic [1:0]  regAddrT;  // register index, R0 reads zero

    // five-state sequence, one instruction per pass
    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stExecute   = 3'd2,
        stMemory    = 3'd3,
        stWriteBack = 3'd4
    } stateT;

    typedef enum logic [2:0] {
        opLw     = 3'd0,
        opSw     = 3'd1,
        opBeqz   = 3'd2,
        opAluReg = 3'd3,  // R-format, fun selects the operation
        opAddi   = 3'd4,
        opSubi   = 3'd5
    } opcodeT;

    typedef enum logic [6:0] {
        funAdd = 7'd0,
        funSub = 7'd1,
        funAnd = 7'd2,
        funOr  = 7'd3,
        funXor = 7'd4,
        funSrl = 7'd5   // logical right shift by one
    } aluFunT;

    typedef struct packed {
        opcodeT  opcode;
        regAddrT src1;
        regAddrT src2;  // also the I-format destination
        regAddrT dst;   // R-format destination
        wordT    imm;   // already sign extended
        aluFunT  fun;
    } instrFieldsT;

    typedef struct packed {
        logic memRef;     // LW or SW
        logic regRegAlu;
        logic regImmAlu;  // ADDI or SUBI
        logic branch;
        logic isLoad;
        logic isStore;
    } decodeT;

    // low 9 bits hold the immediate, bit 8 is its sign
    function automatic wordT immOf(wordT w);
        return {{8{w[8]}}, w[7:0]};
    endfunction

    // instruction bit 0 is the word's msb, fields run big-endian from there
    function automatic instrFieldsT fieldsOf(wordT w);
        instrFieldsT f;
        f.opcode = opcodeT'(w[15:13]);
        f.src1   = w[12:11];
        f.src2   = w[10:9];
        f.dst    = w[8:7];   // overlaps the immediate, format decides
        f.imm    = immOf(w);
        f.fun    = aluFunT'(w[6:0]);
        return f;
    endfunction

endpackage

`default_nettype wire

/* rtl/vsaSequencer.sv */
// control sequencer of the vsa16 core
// state counter, PC and NPC, instruction register
// combinational field extraction and instruction class decode
`timescale 1ns/100ps
`default_nettype none

module vsaSequencer #(
    parameter int unsigned pcWidth = 12
) (
    input  wire                      clock,
    input  wire                      rstN,
    input  wire vsaPkg::wordT        instruction,   // from instruction memory, same cycle
    input  wire                      branchTaken,   // valid from memory state on
    input  wire [pcWidth-1:0]        branchTarget,
    output vsaPkg::stateT            state,
    output vsaPkg::instrFieldsT      fields,
    output vsaPkg::decodeT           decode,
    output logic [pcWidth-1:0]       pc,
    output logic [pcWidth-1:0]       npc
);

    vsaPkg::wordT  ir;          // instruction register
    vsaPkg::stateT nextState;

    // fixed five-step ring
    always_comb begin
        case (state)
            vsaPkg::stFetch:     nextState = vsaPkg::stDecode;
            vsaPkg::stDecode:    nextState = vsaPkg::stExecute;
            vsaPkg::stExecute:   nextState = vsaPkg::stMemory;
            vsaPkg::stMemory:    nextState = vsaPkg::stWriteBack;
            default:             nextState = vsaPkg::stFetch;  // write-back and unused codes
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= vsaPkg::stFetch;
        end else begin
            state <= nextState;
        end
    end

    // IR and NPC load as fetch ends
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            ir  <= '0;
            npc <= '0;
        end else if (state == vsaPkg::stFetch) begin
            ir  <= instruction;
            npc <= pc + pcWidth'(2);   // halfword step
        end
    end

    // pc moves once per instruction, at the end of memory
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (state == vsaPkg::stMemory) begin
            if (branchTaken) begin
                pc <= branchTarget;   // taken BEQZ
            end else begin
                pc <= npc;
            end
        end
    end

    assign fields = vsaPkg::fieldsOf(ir);

    // instruction class flags
    always_comb begin
        decode           = '0;
        decode.isLoad    = fields.opcode == vsaPkg::opLw;
        decode.isStore   = fields.opcode == vsaPkg::opSw;
        decode.memRef    = decode.isLoad | decode.isStore;
        decode.regRegAlu = fields.opcode == vsaPkg::opAluReg;
        decode.regImmAlu = (fields.opcode == vsaPkg::opAddi)
                         | (fields.opcode == vsaPkg::opSubi);
        decode.branch    = fields.opcode == vsaPkg::opBeqz;
        // opcodes 6 and 7 leave every flag low, so they act as no-ops
    end

endmodule

`default_nettype wire

/* rtl/vsaRegFile.sv */
// register file of the vsa16 core
// R1 to R3 storage with R0 reading zero, operand A/B capture
`timescale 1ns/100ps
`default_nettype none

module vsaRegFile (
    input  wire                       clock,
    input  wire                       rstN,
    input  wire vsaPkg::stateT        state,
    input  wire vsaPkg::instrFieldsT  fields,
    input  wire                       wbEn,
    input  wire vsaPkg::regAddrT      wbAddr,
    input  wire vsaPkg::wordT         wbData,
    output vsaPkg::wordT              opA,
    output vsaPkg::wordT              opB
);

    vsaPkg::wordT regs [1:3];   // no storage behind R0
    vsaPkg::wordT rdA;
    vsaPkg::wordT rdB;

    // read ports, zero unless a real register matches
    always_comb begin
        rdA = '0;
        rdB = '0;
        for (int i = 1; i < 4; i++) begin
            if (fields.src1 == 2'(i)) rdA = regs[i];
            if (fields.src2 == 2'(i)) rdB = regs[i];
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 4; i++) begin
                regs[i] <= '0;
            end
            opA <= '0;
            opB <= '0;
        end else begin
            if (state == vsaPkg::stDecode) begin
                opA <= rdA;   // held through execute, memory and write-back
                opB <= rdB;   // also the store data
            end
            if (state == vsaPkg::stWriteBack && wbEn && wbAddr != '0) begin
                regs[wbAddr] <= wbData;   // writes to R0 dropped here
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/vsaExecute.sv */
// execute unit of the vsa16 core
// ALU with address, immediate and branch target paths, zero condition
// load data register, write-back source and destination select, store strobe
`timescale 1ns/100ps
`default_nettype none

module vsaExecute #(
    parameter int unsigned pcWidth = 12
) (
    input  wire                       clock,
    input  wire                       rstN,
    input  wire vsaPkg::stateT        state,
    input  wire vsaPkg::instrFieldsT  fields,
    input  wire vsaPkg::decodeT       decode,
    input  wire [pcWidth-1:0]         npc,
    input  wire vsaPkg::wordT         opA,
    input  wire vsaPkg::wordT         opB,
    input  wire vsaPkg::wordT         dataIn,     // load data, sampled in memory
    output vsaPkg::wordT              aluOut,     // also the data address
    output logic                      branchTaken,
    output logic [pcWidth-1:0]        branchTarget,
    output logic                      wbEn,
    output vsaPkg::regAddrT           wbAddr,
    output vsaPkg::wordT              wbData,
    output logic                      wr
);

    logic         cond;      // opA was zero at execute
    vsaPkg::wordT lmd;       // load memory data
    vsaPkg::wordT aluNext;

    // one result per class, chosen by the decode flags
    always_comb begin
        aluNext = aluOut;   // unknown codes keep the old value
        if (decode.memRef) begin
            aluNext = opA + fields.imm;   // base plus offset
        end else if (decode.regRegAlu) begin
            case (fields.fun)
                vsaPkg::funAdd: aluNext = opA + opB;
                vsaPkg::funSub: aluNext = opA - opB;
                vsaPkg::funAnd: aluNext = opA & opB;
                vsaPkg::funOr:  aluNext = opA | opB;
                vsaPkg::funXor: aluNext = opA ^ opB;
                vsaPkg::funSrl: aluNext = {1'b0, opA[15:1]};
                default:        aluNext = aluOut;
            endcase
        end else if (decode.regImmAlu) begin
            if (fields.opcode == vsaPkg::opSubi) begin
                aluNext = opA - fields.imm;
            end else begin
                aluNext = opA + fields.imm;
            end
        end else if (decode.branch) begin
            // halfword offset from npc
            aluNext = vsaPkg::wordT'(npc) + {fields.imm[14:0], 1'b0};
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            aluOut <= '0;
            cond   <= 1'b0;
        end else if (state == vsaPkg::stExecute) begin
            aluOut <= aluNext;
            if (decode.branch) begin
                cond <= opA == '0;   // BEQZ test
            end
        end
    end

    // load data captured as memory ends
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            lmd <= '0;
        end else if (state == vsaPkg::stMemory && decode.isLoad) begin
            lmd <= dataIn;
        end
    end

    assign branchTaken  = cond & decode.branch;
    assign branchTarget = aluOut[pcWidth-1:0];   // upper bits dropped

    // write-back select, R0 filtering is left to the register file
    assign wbEn   = decode.regRegAlu | decode.regImmAlu | decode.isLoad;
    assign wbAddr = decode.regRegAlu ? fields.dst : fields.src2;
    assign wbData = decode.isLoad ? lmd : aluOut;

    assign wr = (state == vsaPkg::stMemory) & decode.isStore;   // one cycle per SW

endmodule

`default_nettype wire

/* rtl/vsaCore.sv */
// top level of the vsa16 core
// sequencer, register file and execute unit wired to the memory ports
`timescale 1ns/100ps
`default_nettype none

module vsaCore #(
    parameter int unsigned pcWidth = 12
) (
    input  wire                  clock,
    input  wire                  rstN,
    output logic [pcWidth-1:0]   pc,            // instruction address
    input  wire vsaPkg::wordT    instruction,
    output vsaPkg::wordT         aluOut,        // data address
    input  wire vsaPkg::wordT    dataIn,
    output vsaPkg::wordT         dataOut,       // store data
    output logic                 wr             // store strobe
);

    vsaPkg::stateT       state;
    vsaPkg::instrFieldsT fields;
    vsaPkg::decodeT      decode;
    logic [pcWidth-1:0]  npc;
    logic [pcWidth-1:0]  branchTarget;
    logic                branchTaken;
    vsaPkg::wordT        opA;
    logic                wbEn;
    vsaPkg::regAddrT     wbAddr;
    vsaPkg::wordT        wbData;

    vsaSequencer #(.pcWidth(pcWidth)) u_vsaSequencer (
        .clock        (clock),
        .rstN         (rstN),
        .instruction  (instruction),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .state        (state),
        .fields       (fields),
        .decode       (decode),
        .pc           (pc),
        .npc          (npc)
    );

    // opB goes straight out as store data
    vsaRegFile u_vsaRegFile (
        .clock  (clock),
        .rstN   (rstN),
        .state  (state),
        .fields (fields),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData),
        .opA    (opA),
        .opB    (dataOut)
    );

    vsaExecute #(.pcWidth(pcWidth)) u_vsaExecute (
        .clock        (clock),
        .rstN         (rstN),
        .state        (state),
        .fields       (fields),
        .decode       (decode),
        .npc          (npc),
        .opA          (opA),
        .opB          (dataOut),
        .dataIn       (dataIn),
        .aluOut       (aluOut),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .wbEn         (wbEn),
        .wbAddr       (wbAddr),
        .wbData       (wbData),
        .wr           (wr)
    );

endmodule

`default_nettype wire

/* dv/vsaCoreTb.sv */
// testbench for the vsa16 core
// instruction and data memory models, ISA reference model stepped per instruction
// pc, word and strobe compare tasks, watchdog and result summary
`timescale 1ns/100ps
`default_nettype none

module vsaCoreTb;

    localparam int pcWidth  = 12;
    localparam int periodNs = 40;

    logic               clock;
    logic               rstN;
    logic [pcWidth-1:0] pc;
    vsaPkg::wordT       instruction;
    vsaPkg::wordT       aluOut;
    vsaPkg::wordT       dataIn;
    vsaPkg::wordT       dataOut;
    logic               wr;

    vsaPkg::wordT       stim [0:127];      // image of the stimulus file
    vsaPkg::wordT       dataMem [0:255];   // data memory seen by the DUT
    vsaPkg::wordT       modelMem [0:255];  // reference model copy
    vsaPkg::wordT       mReg [0:3];
    logic [pcWidth-1:0] mPc;
    logic               expStore;          // current instruction is SW
    vsaPkg::wordT       expAddr;
    vsaPkg::wordT       expData;
    logic               loopSeen;          // model hit the self-loop
    logic               firstFetch;
    logic               done;
    int phase;                             // 0 fetch .. 4 write-back
    int instrCount;
    int storeCount;
    int storeIdx;
    int strobeCount;
    int checkCount;
    int errorCount;
    int pcErrors;
    int strobeErrors;
    int testCount;
    int failedTests;
    int limitNs;

    // memories answer at once
    assign instruction = stim[{2'b00, pc[5:1]}];
    assign dataIn      = dataMem[aluOut[8:1]];

    always #(periodNs / 2) clock = ~clock;

    vsaCore #(.pcWidth(pcWidth)) u_vsaCore (
        .clock       (clock),
        .rstN        (rstN),
        .pc          (pc),
        .instruction (instruction),
        .aluOut      (aluOut),
        .dataIn      (dataIn),
        .dataOut     (dataOut),
        .wr          (wr)
    );

    task automatic comparePc(input logic [pcWidth-1:0] actual,
                             input logic [pcWidth-1:0] expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            pcErrors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic compareWord(input vsaPkg::wordT actual, input vsaPkg::wordT expected,
                               input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic compareStrobe(input logic actual, input logic expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            strobeErrors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic reportTest(input string name, input int errs);
        testCount++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    // one instruction of the ISA, straight from the encoding rules
    task automatic stepModel();
        vsaPkg::wordT       w;
        vsaPkg::wordT       imm;
        vsaPkg::wordT       a;
        vsaPkg::wordT       b;
        vsaPkg::wordT       addr;
        vsaPkg::wordT       res;
        logic               we;
        vsaPkg::regAddrT    wa;
        logic [pcWidth-1:0] next;
        w    = stim[{2'b00, mPc[5:1]}];
        imm  = {{7{w[8]}}, w[8:0]};   // 9-bit immediate, sign in bit 8
        a    = mReg[w[12:11]];
        b    = mReg[w[10:9]];
        addr = a + imm;
        next = mPc + pcWidth'(2);
        we   = 1'b0;
        wa   = w[10:9];               // I-format destination
        res  = '0;
        expStore = 1'b0;
        case (w[15:13])
            3'd0: begin                               // LW
                we  = 1'b1;
                res = modelMem[addr[8:1]];
            end
            3'd1: begin                               // SW
                expStore = 1'b1;
                expAddr  = addr;
                expData  = b;
                modelMem[addr[8:1]] = b;
            end
            3'd2: begin                               // BEQZ, halfword offset
                if (a == '0) next = next + {imm[pcWidth-2:0], 1'b0};
            end
            3'd3: begin
                wa = w[8:7];
                we = 1'b1;
                case (w[6:0])
                    7'd0:    res = a + b;
                    7'd1:    res = a - b;
                    7'd2:    res = a & b;
                    7'd3:    res = a | b;
                    7'd4:    res = a ^ b;
                    7'd5:    res = {1'b0, a[15:1]};   // SRL by one
                    default: we = 1'b0;
                endcase
            end
            3'd4: begin                               // ADDI
                we  = 1'b1;
                res = a + imm;
            end
            3'd5: begin                               // SUBI
                we  = 1'b1;
                res = a - imm;
            end
            default: we = 1'b0;
        endcase
        if (we) mReg[wa] = res;
        mReg[0]  = '0;   // R0 stays zero
        loopSeen = next == mPc;
        mPc      = next;
    endtask

    task automatic checkStore();
        int errsBefore;
        errsBefore = errorCount;
        strobeCount++;
        if (storeIdx >= storeCount) begin
            errorCount++;
            $display("a store to %h came after all %0d expected stores", aluOut, storeCount);
        end else begin
            compareWord(aluOut, stim[7'(66 + 2 * storeIdx)], "store address");
            compareWord(dataOut, stim[7'(67 + 2 * storeIdx)], "store data");
            compareWord(aluOut, expAddr, "store address from model");
            compareWord(dataOut, expData, "store data from model");
            reportTest($sformatf("store %0d", storeIdx), errorCount - errsBefore);
            storeIdx++;
        end
        dataMem[aluOut[8:1]] = dataOut;
    endtask

    // samples at the falling edge, away from DUT updates
    always @(negedge clock) begin
        if (!rstN) begin
            phase = 0;
            comparePc(pc, '0, "pc during reset");
            compareStrobe(wr, 1'b0, "wr during reset");
        end else if (!done) begin
            if (phase == 0) begin
                comparePc(pc, mPc, "pc at fetch");
                if (firstFetch) begin
                    reportTest("reset and first fetch", pcErrors + strobeErrors);
                    firstFetch = 1'b0;
                end
                if (loopSeen && storeIdx == storeCount) begin
                    done = 1'b1;
                end else begin
                    stepModel();
                end
            end
            compareStrobe(wr, phase == 3 && expStore, "wr");
            if (wr === 1'b1) checkStore();
            phase = (phase == 4) ? 0 : phase + 1;
        end
    end

    initial begin
        clock = 1'b0;
        rstN  <= 1'b0;
        $readmemh("dv/vsaStimulus.txt", stim);
        for (int i = 0; i < 256; i++) begin
            // initial data at words 0x20 to 0x3f, address pattern elsewhere
            dataMem[8'(i)]  = (i >= 32 && i < 64) ? stim[7'(i)] : {~8'(i), 8'(i)};
            modelMem[8'(i)] = dataMem[8'(i)];
        end
        for (int i = 0; i < 4; i++) begin
            mReg[2'(i)] = '0;
        end
        instrCount = int'(stim[64]);
        storeCount = int'(stim[65]);
        mPc        = '0;
        expStore   = 1'b0;
        loopSeen   = 1'b0;
        firstFetch = 1'b1;
        done       = 1'b0;
        repeat (8) @(posedge clock);
        rstN <= 1'b1;
        wait (done);
        reportTest("pc sequence and branches", pcErrors);
        if (strobeCount != storeCount) begin
            errorCount++;
            strobeErrors++;
            $display("counted %0d store strobes, expected %0d", strobeCount, storeCount);
        end
        reportTest("store strobe", strobeErrors);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog, 5 cycles per instruction plus reset and a few spare instructions
    initial begin
        #1;
        limitNs = ((instrCount + 4) * 5 + 8) * periodNs;
        #(limitNs - 1);
        $display("timeout after %0d ns with %0d of %0d expected stores seen",
                 limitNs, storeIdx, storeCount);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/vsaStimulus.txt */
// vsa16 stimulus: @00 program words by pc/2, @20 initial data words from byte 0x40,
// @40 instruction count and store count, then one address/data pair per expected store
@00
8235 AC5A 2280 2482   // addi r1, subi r2, store both
6D80 2684 6D81 2686   // add, sub with stores
6D82 2688 6D83 268A   // and, or with stores
6D84 268C 7185 268E   // xor, srl with stores
8650 1BF0 3A40 19F2   // base r3, lw r1 at -16, store it, lw into r0
887F 2092 4805 4002   // addi into r0, store r0, beqz not taken, beqz taken
8201 2294 2296 41FF   // two skipped words, store r1, self-loop
@20
C3A5 1234             // read by the two loads
@40
001A 000B             // instructions to the loop, expected stores
0080 0035  0082 FFDB
0084 0010  0086 005A
0088 0011  008A FFFF
008C FFEE  008E 7FED
0090 C3A5  0092 0000
0096 C3A5

/* all.f */
rtl/vsaPkg.sv
rtl/vsaSequencer.sv
rtl/vsaRegFile.sv
rtl/vsaExecute.sv
rtl/vsaCore.sv
dv/vsaCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f all.f \
    --top-module vsaCoreTb -o vsaCoreSim
output="$(./obj_dir/vsaCoreSim)"
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
fi
exit 1
